//--- verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes kept by this core
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // funct3 for register and immediate arithmetic
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    // funct7, the alternate form selects sub and sra
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // one instruction word, read through whichever format applies
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

endpackage

`default_nettype wire

//--- verilog/core_pipe_pkg.sv
`default_nettype none

package core_pipe_pkg;

    localparam logic [rv_isa_pkg::xlen-1:0] start_addr = 32'h0000_0000;
    localparam int imem_depth  = 64;
    localparam int imem_addr_w = 6;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_jal
    } branch_e;

    // decode to execute payload
    typedef struct packed {
        logic                              valid;
        logic [rv_isa_pkg::xlen-1:0]       pc;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic                              reg_we;
        alu_op_e                           alu_op;
        branch_e                           branch;
        logic                              use_imm;
        logic [rv_isa_pkg::xlen-1:0]       rs1_val;
        logic [rv_isa_pkg::xlen-1:0]       rs2_val;
        logic [rv_isa_pkg::xlen-1:0]       imm;
    } dec_bundle_t;

    // execute result, also used for forwarding
    typedef struct packed {
        logic                              valid;
        logic [rv_isa_pkg::xlen-1:0]       pc;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic                              reg_we;
        logic [rv_isa_pkg::xlen-1:0]       data;
    } res_bundle_t;

endpackage

`default_nettype wire

//--- verilog/writeback_if.sv
`default_nettype none

interface writeback_if;
    import rv_isa_pkg::*;

    logic                  valid;
    logic                  we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;

    // writeback side
    modport driver (output valid, we, rd, data);

    // register file and forwarding side
    modport sink (input valid, we, rd, data);

endinterface

`default_nettype wire

//--- verilog/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 run,
    input  logic                                 imem_we,
    input  logic [core_pipe_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]          imem_wdata,
    input  logic                                 redirect,
    input  logic [rv_isa_pkg::xlen-1:0]          redirect_pc,
    output logic                                 fetch_valid,
    output logic [rv_isa_pkg::xlen-1:0]          fetch_pc,
    output logic [rv_isa_pkg::xlen-1:0]          fetch_inst
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic [xlen-1:0]        imem [imem_depth];
    logic [xlen-1:0]        pc;
    logic [imem_addr_w-1:0] pc_idx;

    // word index, the memory wraps past its last word
    assign pc_idx = pc[imem_addr_w+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= start_addr;
            fetch_valid <= 1'b0;
        end
        else if (!run) begin
            // halted, hold at the reset address
            pc          <= start_addr;
            fetch_valid <= 1'b0;
        end
        else begin
            // the word read this cycle is stale once a branch is taken
            fetch_valid <= !redirect;
            if (redirect) begin
                pc <= redirect_pc;
            end
            else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // program load port and synchronous read
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
        fetch_inst <= imem[pc_idx];
        fetch_pc   <= pc;
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_valid,
    input  logic [rv_isa_pkg::xlen-1:0] fetch_pc,
    input  logic [rv_isa_pkg::xlen-1:0] fetch_inst,
    input  logic                        redirect,
    input  core_pipe_pkg::res_bundle_t  ex_fwd,
    writeback_if.sink                   wb,
    output core_pipe_pkg::dec_bundle_t  dec
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    inst_word_u            inst;
    logic [xlen-1:0]       regs [32];
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm_u;
    logic [xlen-1:0]       imm_j;
    logic                  alt_f7;
    logic                  shift_op;
    alu_op_e               alu_sel;
    dec_bundle_t           dec_next;

    // newest value wins: execute, then writeback, then the register file
    function automatic logic [xlen-1:0] operand(input logic [reg_addr_w-1:0] rs,
                                                input logic [xlen-1:0] rf_val);
        logic [xlen-1:0] val;
        if (rs == '0) begin
            val = '0;
        end
        else if (ex_fwd.valid && ex_fwd.reg_we && ex_fwd.rd == rs) begin
            val = ex_fwd.data;
        end
        else if (wb.valid && wb.we && wb.rd == rs) begin
            val = wb.data;
        end
        else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign inst = fetch_inst;
    assign rs1  = inst.r_fmt.rs1;
    assign rs2  = inst.r_fmt.rs2;

    assign rs1_val = operand(rs1, regs[rs1]);
    assign rs2_val = operand(rs2, regs[rs2]);

    // sign-extended immediate of each format
    assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    assign alt_f7   = (inst.r_fmt.funct7 == f7_alt);
    assign shift_op = (inst.r_fmt.funct3 == f3_sll) || (inst.r_fmt.funct3 == f3_srl_sra);

    always_comb begin
        case (inst.r_fmt.funct3)
            f3_add_sub: alu_sel = alu_add;
            f3_sll:     alu_sel = alu_sll;
            f3_slt:     alu_sel = alu_slt;
            f3_sltu:    alu_sel = alu_sltu;
            f3_xor:     alu_sel = alu_xor;
            f3_srl_sra: alu_sel = alt_f7 ? alu_sra : alu_srl;
            f3_or:      alu_sel = alu_or;
            f3_and:     alu_sel = alu_and;
            default:    alu_sel = alu_add;
        endcase
    end

    always_comb begin
        dec_next.valid   = fetch_valid && !redirect;
        dec_next.pc      = fetch_pc;
        dec_next.rd      = inst.r_fmt.rd;
        dec_next.reg_we  = 1'b0;
        dec_next.alu_op  = alu_sel;
        dec_next.branch  = br_none;
        dec_next.use_imm = 1'b0;
        dec_next.rs1_val = rs1_val;
        dec_next.rs2_val = rs2_val;
        dec_next.imm     = imm_i;

        // unknown encodings keep reg_we low and retire as no-ops
        case (inst.r_fmt.opcode)
            op_reg: begin
                dec_next.reg_we = (inst.r_fmt.funct7 == f7_base) ||
                                  (alt_f7 && (inst.r_fmt.funct3 == f3_add_sub ||
                                              inst.r_fmt.funct3 == f3_srl_sra));
                if (inst.r_fmt.funct3 == f3_add_sub && alt_f7) begin
                    dec_next.alu_op = alu_sub;
                end
            end
            op_imm: begin
                // funct7 only matters for the shifts
                dec_next.use_imm = 1'b1;
                dec_next.reg_we  = !shift_op || (inst.r_fmt.funct7 == f7_base) ||
                                   (alt_f7 && inst.r_fmt.funct3 == f3_srl_sra);
            end
            op_lui: begin
                dec_next.alu_op  = alu_pass_b;
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_u;
                dec_next.reg_we  = 1'b1;
            end
            op_branch: begin
                dec_next.imm = imm_b;
                case (inst.b_fmt.funct3)
                    f3_beq:  dec_next.branch = br_beq;
                    f3_bne:  dec_next.branch = br_bne;
                    f3_blt:  dec_next.branch = br_blt;
                    f3_bge:  dec_next.branch = br_bge;
                    default: dec_next.branch = br_none;
                endcase
            end
            op_jal: begin
                dec_next.imm    = imm_j;
                dec_next.branch = br_jal;
                dec_next.reg_we = 1'b1;
            end
            default: begin
                dec_next.reg_we = 1'b0;
            end
        endcase
    end

    // register file, x0 never gets a write enable
    always_ff @(posedge clk) begin
        if (wb.valid && wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        dec <= dec_next;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  core_pipe_pkg::dec_bundle_t  dec,
    output core_pipe_pkg::res_bundle_t  ex_fwd,
    output core_pipe_pkg::res_bundle_t  res,
    output logic                        redirect,
    output logic [rv_isa_pkg::xlen-1:0] redirect_pc
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [4:0]      shamt;
    logic            taken;

    assign op_a  = dec.rs1_val;
    assign op_b  = dec.use_imm ? dec.imm : dec.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_sll:    alu_out = op_a << shamt;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // branch condition always compares the two registers
    always_comb begin
        case (dec.branch)
            br_beq:  taken = (dec.rs1_val == dec.rs2_val);
            br_bne:  taken = (dec.rs1_val != dec.rs2_val);
            br_blt:  taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
            br_bge:  taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = dec.valid && taken;
    assign redirect_pc = dec.pc + dec.imm;

    // combinational result, the newest forwarding source
    always_comb begin
        ex_fwd.valid  = dec.valid;
        ex_fwd.pc     = dec.pc;
        ex_fwd.rd     = dec.rd;
        ex_fwd.reg_we = dec.reg_we;
        // jal links the return address
        ex_fwd.data   = (dec.branch == br_jal) ? dec.pc + 32'd4 : alu_out;
    end

    always_ff @(posedge clk) begin
        res <= ex_fwd;
        if (!rst_n) begin
            res.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  core_pipe_pkg::res_bundle_t        res,
    writeback_if.driver                       wb,
    output logic                              retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    output logic                              retire_wen,
    output logic [rv_isa_pkg::xlen-1:0]       retire_data
);
    logic wen;

    // x0 stays zero
    assign wen = res.reg_we && (res.rd != '0);

    // register file write happens at the end of this cycle
    assign wb.valid = res.valid;
    assign wb.we    = wen;
    assign wb.rd    = res.rd;
    assign wb.data  = res.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end
        else begin
            retire_valid <= res.valid;
        end
    end

    // retire record
    always_ff @(posedge clk) begin
        retire_pc   <= res.pc;
        retire_rd   <= res.rd;
        retire_wen  <= wen;
        retire_data <= res.data;
    end

endmodule

`default_nettype wire

//--- verilog/rv_core_top.sv
`default_nettype none

module rv_core_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  run,
    input  logic                                  imem_we,
    input  logic [core_pipe_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]           imem_wdata,
    output logic                                  retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]           retire_pc,
    output logic [rv_isa_pkg::reg_addr_w-1:0]     retire_rd,
    output logic                                  retire_wen,
    output logic [rv_isa_pkg::xlen-1:0]           retire_data
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic            fetch_valid;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] fetch_inst;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    dec_bundle_t     dec;
    res_bundle_t     ex_fwd;
    res_bundle_t     res;

    writeback_if wb_link ();

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .redirect    (redirect),
        .ex_fwd      (ex_fwd),
        .wb          (wb_link.sink),
        .dec         (dec)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec),
        .ex_fwd      (ex_fwd),
        .res         (res),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (res),
        .wb           (wb_link.driver),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

//--- tests/core_props.sv
`default_nettype none

module core_props (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              run,
    input logic                              retire_valid,
    input logic [rv_isa_pkg::xlen-1:0]       retire_pc,
    input logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    input logic                              retire_wen
);
    // a retire needs run high when its pc was issued, four cycles back
    retire_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> $past(run, 4))
        else $error("retire reported while the core was halted");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && retire_wen |-> retire_rd != '0)
        else $error("retire write enable set for x0");

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_pc[1:0] == 2'b00)
        else $error("retire pc not word aligned");

    // even the self loop needs three cycles per pass
    pc_moves_on: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && $past(retire_valid) |-> retire_pc != $past(retire_pc))
        else $error("same pc retired on two consecutive cycles");

endmodule

bind rv_core_top core_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen)
);

`default_nettype wire

//--- tests/core_tb.sv
`default_nettype none

module core_tb;
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int mode_idle   = 0;
    localparam int mode_alu    = 1;
    localparam int mode_fwd    = 2;
    localparam int mode_branch = 3;
    localparam int mode_mixed  = 4;
    localparam int num_tests   = 5;
    // program load, then up to four cycles per word plus slack, per test
    localparam int timeout_limit = num_tests * (imem_depth + imem_depth * 4 + 20);

    logic                   clk;
    logic                   rst_n;
    logic                   run;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic                   retire_valid;
    logic [xlen-1:0]        retire_pc;
    logic [reg_addr_w-1:0]  retire_rd;
    logic                   retire_wen;
    logic [xlen-1:0]        retire_data;

    logic [xlen-1:0]       prog [imem_depth];
    logic [xlen-1:0]       exp_pc [$];
    logic [reg_addr_w-1:0] exp_rd [$];
    logic                  exp_wen [$];
    logic [xlen-1:0]       exp_data [$];

    integer seed;
    int     cycles = 0;
    int     test_errors;
    int     pass_count;
    int     fail_count;

    rv_core_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_limit) begin
            $display("timeout: the core stopped retiring within %0d cycles", timeout_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // kinds 0-9 register ops, 10-19 immediate ops with lui at 11
    function automatic logic [31:0] alu_inst(input int kind, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [31:0] r);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (kind == 1 || kind == 7 || kind == 17) ? f7_alt : f7_base;
        case (kind % 10)
            0, 1:    f3 = f3_add_sub;
            2:       f3 = f3_sll;
            3:       f3 = f3_slt;
            4:       f3 = f3_sltu;
            5:       f3 = f3_xor;
            6, 7:    f3 = f3_srl_sra;
            8:       f3 = f3_or;
            default: f3 = f3_and;
        endcase
        if (kind < 10) begin
            return {f7, rs2, rs1, f3, rd, op_reg};
        end
        else if (kind == 11) begin
            return {r[19:0], rd, op_lui};
        end
        else if (kind == 12 || kind == 16 || kind == 17) begin
            return {f7, r[4:0], rs1, f3, rd, op_imm};
        end
        return {r[11:0], rs1, f3, rd, op_imm};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // RV32I arithmetic by funct3, alt picks sub or sra
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            f3_add_sub: return alt ? a - b : a + b;
            f3_sll:     return a << b[4:0];
            f3_slt:     return {31'b0, $signed(a) < $signed(b)};
            f3_sltu:    return {31'b0, a < b};
            f3_xor:     return a ^ b;
            f3_srl_sra: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            f3_or:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    task automatic make_program(input int mode);
        logic [31:0] r;
        logic [31:0] val;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        logic [2:0]  f3;
        int          kind;
        int          k;
        // x1..x7 get known values first
        for (int i = 0; i < 7; i++) begin
            prog[i] = alu_inst(10, 5'(i + 1), 5'd0, 5'd0, $random(seed));
        end
        prev1 = 5'd7;
        prev2 = 5'd6;
        for (int i = 7; i < imem_depth - 1; i++) begin
            r    = $random(seed);
            val  = $random(seed);
            rd   = {2'b00, r[2:0]};
            rs1  = {2'b00, r[5:3]};
            rs2  = {2'b00, r[8:6]};
            kind = int'(r[31:16]) % 20;
            k    = 1 + int'(r[10:9]);
            if (i + k > imem_depth - 1) begin
                k = imem_depth - 1 - i;
            end
            f3 = r[15] ? (r[14] ? f3_bge : f3_blt) : (r[14] ? f3_bne : f3_beq);
            case (mode)
                mode_alu: prog[i] = alu_inst(i % 20, rd, rs1, rs2, val);
                mode_fwd: begin
                    // each word reads the two results just before it
                    prog[i] = alu_inst(kind, rd, prev1, prev2, val);
                    prev2   = prev1;
                    prev1   = rd;
                end
                mode_branch: begin
                    if (i % 4 != 3) begin
                        prog[i] = alu_inst(kind, rd, rs1, rs2, val);
                    end
                    else if (r[12:11] == 2'd0) begin
                        prog[i] = branch_inst(f3_beq, rs1, rs1, 13'(k * 4));
                    end
                    else if (r[12:11] == 2'd1) begin
                        prog[i] = branch_inst(f3_bge, rs1, rs1, 13'(k * 4));
                    end
                    else begin
                        prog[i] = jal_inst(rd, 21'(k * 4));
                    end
                end
                default: begin
                    if (r[13:11] == 3'd0) begin
                        prog[i] = branch_inst(f3, rs1, rs2, 13'(k * 4));
                    end
                    else if (r[13:11] == 3'd1) begin
                        prog[i] = jal_inst(rd, 21'(k * 4));
                    end
                    else begin
                        prog[i] = alu_inst(kind, rd, rs1, rs2, val);
                    end
                end
            endcase
        end
        // last word loops on itself
        prog[imem_depth - 1] = branch_inst(f3_beq, 5'd0, 5'd0, 13'd0);
    endtask

    // steps the program once through and queues every expected retire
    task automatic build_trace();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wen;
        logic        taken;
        logic        done;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_wen.delete();
        exp_data.delete();
        pc   = start_addr;
        done = 1'b0;
        while (!done) begin
            w       = prog[pc[imem_addr_w+1:2]];
            rd      = w[11:7];
            f3      = w[14:12];
            a       = x[w[19:15]];
            b       = x[w[24:20]];
            val     = '0;
            wen     = 1'b0;
            taken   = 1'b0;
            next_pc = pc + 32'd4;
            case (w[6:0])
                op_reg: begin
                    wen = 1'b1;
                    val = alu_model(f3, w[30], a, b);
                end
                op_imm: begin
                    wen = 1'b1;
                    val = alu_model(f3, w[30] && f3 == f3_srl_sra, a, {{20{w[31]}}, w[31:20]});
                end
                op_lui: begin
                    wen = 1'b1;
                    val = {w[31:12], 12'b0};
                end
                op_branch: begin
                    case (f3)
                        f3_beq:  taken = (a == b);
                        f3_bne:  taken = (a != b);
                        f3_blt:  taken = ($signed(a) < $signed(b));
                        default: taken = ($signed(a) >= $signed(b));
                    endcase
                    if (taken) begin
                        next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                op_jal: begin
                    wen     = 1'b1;
                    val     = pc + 32'd4;
                    next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                default: ;
            endcase
            wen = wen && (rd != 5'd0);
            if (wen) begin
                x[rd] = val;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_wen.push_back(wen);
            exp_data.push_back(val);
            done = (pc == 32'((imem_depth - 1) * 4));
            pc   = next_pc;
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic load_program(input string name);
        for (int i = 0; i < imem_depth; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= imem_addr_w'(i);
            imem_wdata <= prog[i];
            @(negedge clk);
            if (retire_valid) begin
                $display("%s: a retire appeared while the program was loading", name);
                test_errors++;
            end
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic report_mismatch(input string name, input int idx, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Error %s: retire %0d %s expected %h actual %h",
                 name, idx, field, expected, actual);
        test_errors++;
    endtask

    task automatic run_test(input string name, input int mode);
        int n;
        test_errors = 0;
        n = 0;
        reset_core();
        make_program(mode);
        build_trace();
        load_program(name);
        if (mode == mode_idle) begin
            // halted core stays quiet after the load too
            repeat (10) begin
                @(negedge clk);
                if (retire_valid) begin
                    $display("%s: a retire appeared while run was low", name);
                    test_errors++;
                end
            end
        end
        else begin
            @(posedge clk);
            run <= 1'b1;
            for (n = 0; n < exp_pc.size(); n++) begin
                @(negedge clk);
                while (!retire_valid) begin
                    @(negedge clk);
                end
                if (retire_pc !== exp_pc[n]) begin
                    report_mismatch(name, n, "pc", exp_pc[n], retire_pc);
                end
                if (retire_wen !== exp_wen[n]) begin
                    report_mismatch(name, n, "wen", 32'(exp_wen[n]), 32'(retire_wen));
                end
                if (exp_wen[n] && retire_rd !== exp_rd[n]) begin
                    report_mismatch(name, n, "rd", 32'(exp_rd[n]), 32'(retire_rd));
                end
                if (exp_wen[n] && retire_data !== exp_data[n]) begin
                    report_mismatch(name, n, "data", exp_data[n], retire_data);
                end
            end
            @(posedge clk);
            run <= 1'b0;
            repeat (6) @(posedge clk);
        end
        if (test_errors == 0) begin
            pass_count++;
        end
        else begin
            fail_count++;
        end
        $display("%s: %0d retires checked, %0d errors", name, n, test_errors);
    endtask

    initial begin
        seed       = 32'hd86f;
        pass_count = 0;
        fail_count = 0;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        run_test("idle_load", mode_idle);
        run_test("alu_ops", mode_alu);
        run_test("forwarding", mode_fwd);
        run_test("taken_branches", mode_branch);
        run_test("mixed_program", mode_mixed);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end
        else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/rv_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/writeback_if.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core_top.sv
tests/core_props.sv
tests/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module core_tb -o core_sim

out=$(./obj_dir/core_sim || true)
printf '%s\n' "$out"

# exit status follows the pass message
printf '%s\n' "$out" | grep -qx 'Testbench passed'
